//--- bk_geom_pkg.sv
package bk_geom_pkg;

	////////////////////////////////////////////////////////////////////////////
	// image layout

	// internal backup ram occupies the first sectors of the image
	localparam int BRAM_SECTORS = 16;
	// one sd sector is 256 sixteen-bit words
	localparam int SECTOR_WORDS = 256;
	localparam int SD_ADDR_W = $clog2(SECTOR_WORDS);

	////////////////////////////////////////////////////////////////////////////
	// address widths

	// console byte port, 8 KB
	localparam int BRAM_ADDR_W = 13;
	// byte address inside the one-sector staging buffer
	localparam int BUF_ADDR_W = 9;
	localparam int LBA_W = 11;
	// 10-bit cartridge sector above the 9-bit byte
	localparam int CART_ADDR_W = 19;

	// region 0 is internal ram, anything else is cartridge
	typedef struct packed {
		logic [6:0] region;
		logic [3:0] sector;
	} bk_lba_int_s;

	typedef union packed {
		bk_lba_int_s internal;
		logic [LBA_W-1:0] flat;
	} bk_lba_u;

endpackage

//--- bk_ctrl_pkg.sv
package bk_ctrl_pkg;

	// direction of a whole transfer as seen from the console
	typedef enum logic {
		DIR_SAVE = 1'b0,
		DIR_LOAD = 1'b1
	} bk_dir_e;

	// three steps of one cartridge sector
	// load: sd read, copy out, advance
	// save: copy in, sd write, advance
	typedef enum logic [1:0] {
		SEQ_ISSUE   = 2'd0,
		SEQ_STEP    = 2'd1,
		SEQ_ADVANCE = 2'd2
	} seq_state_e;

endpackage

//--- bk_request_ctl.sv
`timescale 1ns/10ps

module bk_request_ctl (
	input  logic clk_sys,
	input  logic rst,
	input  logic save_download,
	input  logic rom_download,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic bk_load,
	input  logic bk_save,
	input  logic autosave,
	input  logic osd_status,
	input  logic bram_we,
	input  logic cart_en,
	input  logic cart_change,
	input  logic bk_busy,
	output logic bk_ena,
	output logic sav_pending,
	output logic start,
	output logic start_reload,
	output bk_ctrl_pkg::bk_dir_e start_dir
);

	logic save_dl_d;
	logic rom_dl_d;
	logic change_d;
	logic load_d;
	logic save_d;
	logic osd_d;
	logic change;
	logic load_rise;
	logic save_rise;
	logic auto_rise;
	logic rom_fall;

	// cartridge writes only count when that ram is part of the image
	assign change = bram_we | (cart_en & cart_change);

	assign load_rise = bk_load & ~load_d;
	assign save_rise = bk_save & ~save_d;
	assign auto_rise = osd_status & ~osd_d & autosave & sav_pending;
	assign rom_fall  = rom_dl_d & ~rom_download;

	assign start = bk_ena & ~bk_busy & (load_rise | save_rise | auto_rise | rom_fall);
	// reload pulse to the console only for a load from the menu
	assign start_reload = load_rise & ~rom_fall;

	always_comb begin
		if (load_rise || rom_fall) begin
			start_dir = bk_ctrl_pkg::DIR_LOAD;
		end else begin
			start_dir = bk_ctrl_pkg::DIR_SAVE;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			save_dl_d   <= 1'b0;
			rom_dl_d    <= 1'b0;
			change_d    <= 1'b0;
			load_d      <= 1'b0;
			save_d      <= 1'b0;
			osd_d       <= 1'b0;
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			save_dl_d <= save_download;
			rom_dl_d  <= rom_download;
			change_d  <= change;
			load_d    <= bk_load;
			save_d    <= bk_save;
			osd_d     <= osd_status;

			// save image gets mounted at the end of its download
			if (!save_dl_d && save_download) begin
				bk_ena <= 1'b0;
			end
			if (save_download && img_mounted && !img_readonly) begin
				bk_ena <= 1'b1;
			end

			if (!change_d && change) begin
				sav_pending <= 1'b1;
			end else if (bk_busy) begin
				sav_pending <= 1'b0;
			end
		end
	end

endmodule

//--- bk_sector_seq.sv
`timescale 1ns/10ps

module bk_sector_seq #(
	parameter int CART_SECTORS = 1024
) (
	input  logic clk_sys,
	input  logic rst,
	input  logic start,
	input  logic start_reload,
	input  bk_ctrl_pkg::bk_dir_e start_dir,
	input  logic cart_en,
	input  logic sd_ack,
	input  logic copy_done,
	output logic sd_rd,
	output logic sd_wr,
	output bk_geom_pkg::bk_lba_u sd_lba,
	output logic bk_busy,
	output logic bk_loading,
	output logic bk_reload,
	output logic copy_start
);

	localparam int LBA_W = bk_geom_pkg::LBA_W;
	// last cartridge sector on the image
	localparam logic [LBA_W-1:0] LAST_LBA =
		LBA_W'(bk_geom_pkg::BRAM_SECTORS + CART_SECTORS - 1);

	bk_ctrl_pkg::seq_state_e phase;
	logic ack_d;
	logic ack_rise;
	logic ack_fall;
	logic is_load;
	logic last_cart;

	assign ack_rise  = sd_ack & ~ack_d;
	assign ack_fall  = ack_d & ~sd_ack;
	assign is_load   = (start_dir == bk_ctrl_pkg::DIR_LOAD);
	assign last_cart = (sd_lba.flat == LAST_LBA);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ack_d      <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			bk_reload  <= 1'b0;
			copy_start <= 1'b0;
			phase      <= bk_ctrl_pkg::SEQ_ISSUE;
		end else begin
			ack_d <= sd_ack;

			// host has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				phase      <= bk_ctrl_pkg::SEQ_ISSUE;
				copy_start <= 1'b0;
				sd_lba     <= '0;
				bk_loading <= 1'b0;
				bk_reload  <= 1'b0;
				if (start) begin
					bk_busy    <= 1'b1;
					bk_loading <= is_load;
					bk_reload  <= start_reload;
					sd_rd      <= is_load;
					sd_wr      <= ~is_load;
				end
			end else if (sd_lba.internal.region == '0) begin
				//////////////////////////////////////////////////////////////////
				// internal sectors, one sd request each
				if (ack_fall) begin
					sd_lba.flat <= sd_lba.flat + 1'b1;
					if (&sd_lba.internal.sector) begin
						// cartridge region follows only when enabled
						if (!cart_en) begin
							bk_busy <= 1'b0;
						end
					end else begin
						sd_rd <= bk_loading;
						sd_wr <= ~bk_loading;
					end
				end
			end else if (bk_loading) begin
				//////////////////////////////////////////////////////////////////
				// cartridge load: read sector into staging, then copy out
				case (phase)
					bk_ctrl_pkg::SEQ_ISSUE: begin
						sd_rd <= 1'b1;
						phase <= bk_ctrl_pkg::SEQ_STEP;
					end
					bk_ctrl_pkg::SEQ_STEP: begin
						if (ack_fall) begin
							copy_start <= 1'b1;
							phase      <= bk_ctrl_pkg::SEQ_ADVANCE;
						end
					end
					bk_ctrl_pkg::SEQ_ADVANCE: begin
						if (copy_done) begin
							copy_start  <= 1'b0;
							sd_lba.flat <= sd_lba.flat + 1'b1;
							phase       <= bk_ctrl_pkg::SEQ_ISSUE;
							if (last_cart) begin
								bk_busy <= 1'b0;
							end
						end
					end
					default: phase <= bk_ctrl_pkg::SEQ_ISSUE;
				endcase
			end else begin
				//////////////////////////////////////////////////////////////////
				// cartridge save: copy into staging, then write sector
				case (phase)
					bk_ctrl_pkg::SEQ_ISSUE: begin
						copy_start <= 1'b1;
						phase      <= bk_ctrl_pkg::SEQ_STEP;
					end
					bk_ctrl_pkg::SEQ_STEP: begin
						if (copy_done) begin
							copy_start <= 1'b0;
							sd_wr      <= 1'b1;
							phase      <= bk_ctrl_pkg::SEQ_ADVANCE;
						end
					end
					bk_ctrl_pkg::SEQ_ADVANCE: begin
						if (ack_fall) begin
							sd_lba.flat <= sd_lba.flat + 1'b1;
							phase       <= bk_ctrl_pkg::SEQ_ISSUE;
							if (last_cart) begin
								bk_busy <= 1'b0;
							end
						end
					end
					default: phase <= bk_ctrl_pkg::SEQ_ISSUE;
				endcase
			end
		end
	end

endmodule

//--- bk_sector_store.sv
`timescale 1ns/10ps

module bk_sector_store (
	input  logic clk_sys,
	input  logic [bk_geom_pkg::BRAM_ADDR_W-1:0] bram_addr,
	input  logic [7:0] bram_wdata,
	input  logic bram_we,
	input  bk_geom_pkg::bk_lba_u sd_lba,
	input  logic [bk_geom_pkg::SD_ADDR_W-1:0] sd_buff_addr,
	input  logic [15:0] sd_buff_dout,
	input  logic sd_buff_wr,
	input  logic sd_ack,
	input  logic [bk_geom_pkg::BUF_ADDR_W-1:0] buf_addr,
	input  logic [7:0] buf_wdata,
	input  logic buf_we,
	output logic [7:0] bram_rdata,
	output logic [7:0] buf_rdata,
	output logic [15:0] sd_buff_din
);

	localparam int BRAM_WORDS = bk_geom_pkg::BRAM_SECTORS * bk_geom_pkg::SECTOR_WORDS;
	localparam int BRAM_ADDR_W = bk_geom_pkg::BRAM_ADDR_W;
	localparam int BUF_ADDR_W = bk_geom_pkg::BUF_ADDR_W;

	// low lane holds even bytes, high lane odd bytes
	logic [7:0] bram_lo [BRAM_WORDS];
	logic [7:0] bram_hi [BRAM_WORDS];
	logic [7:0] buf_lo [bk_geom_pkg::SECTOR_WORDS];
	logic [7:0] buf_hi [bk_geom_pkg::SECTOR_WORDS];

	logic [BRAM_ADDR_W-2:0] bram_sd_addr;
	logic [15:0] bram_sd_q;
	logic [15:0] buf_sd_q;
	logic cart_sel;
	logic bram_sd_we;
	logic buf_sd_we;

	assign cart_sel     = (sd_lba.internal.region != '0);
	assign bram_sd_addr = {sd_lba.internal.sector, sd_buff_addr};
	assign bram_sd_we   = sd_buff_wr & sd_ack & ~cart_sel;
	assign buf_sd_we    = sd_buff_wr & sd_ack & cart_sel;

	assign sd_buff_din = cart_sel ? buf_sd_q : bram_sd_q;

	////////////////////////////////////////////////////////////////////////////
	// internal backup ram, console byte port and sd word port
	always_ff @(posedge clk_sys) begin
		if (bram_we && !bram_addr[0]) begin
			bram_lo[bram_addr[BRAM_ADDR_W-1:1]] <= bram_wdata;
		end
		if (bram_we && bram_addr[0]) begin
			bram_hi[bram_addr[BRAM_ADDR_W-1:1]] <= bram_wdata;
		end
		if (bram_sd_we) begin
			bram_lo[bram_sd_addr] <= sd_buff_dout[7:0];
			bram_hi[bram_sd_addr] <= sd_buff_dout[15:8];
		end
		bram_rdata <= bram_addr[0] ? bram_hi[bram_addr[BRAM_ADDR_W-1:1]]
			: bram_lo[bram_addr[BRAM_ADDR_W-1:1]];
		bram_sd_q <= {bram_hi[bram_sd_addr], bram_lo[bram_sd_addr]};
	end

	////////////////////////////////////////////////////////////////////////////
	// staging buffer, copier byte port and sd word port
	always_ff @(posedge clk_sys) begin
		if (buf_we && !buf_addr[0]) begin
			buf_lo[buf_addr[BUF_ADDR_W-1:1]] <= buf_wdata;
		end
		if (buf_we && buf_addr[0]) begin
			buf_hi[buf_addr[BUF_ADDR_W-1:1]] <= buf_wdata;
		end
		if (buf_sd_we) begin
			buf_lo[sd_buff_addr] <= sd_buff_dout[7:0];
			buf_hi[sd_buff_addr] <= sd_buff_dout[15:8];
		end
		buf_rdata <= buf_addr[0] ? buf_hi[buf_addr[BUF_ADDR_W-1:1]]
			: buf_lo[buf_addr[BUF_ADDR_W-1:1]];
		buf_sd_q <= {buf_hi[sd_buff_addr], buf_lo[sd_buff_addr]};
	end

endmodule

//--- bk_cart_copier.sv
`timescale 1ns/10ps

module bk_cart_copier (
	input  logic clk_sys,
	input  logic rst,
	input  logic copy_start,
	input  bk_ctrl_pkg::bk_dir_e copy_dir,
	input  bk_geom_pkg::bk_lba_u sd_lba,
	input  logic cart_busy,
	input  logic [7:0] cart_rdata,
	input  logic [7:0] buf_rdata,
	output logic copy_done,
	output logic [bk_geom_pkg::CART_ADDR_W-1:0] cart_addr,
	output logic [7:0] cart_wdata,
	output logic cart_rd,
	output logic cart_wr,
	output logic [bk_geom_pkg::BUF_ADDR_W-1:0] buf_addr,
	output logic buf_we,
	output logic [7:0] buf_wdata
);

	localparam int LBA_W = bk_geom_pkg::LBA_W;
	localparam int CART_SEC_W = bk_geom_pkg::CART_ADDR_W - bk_geom_pkg::BUF_ADDR_W;

	logic [CART_SEC_W-1:0] cart_sec;
	logic busy_d;
	logic waiting;
	logic busy_rise;
	logic busy_fall;

	assign busy_rise = cart_busy & ~busy_d;
	assign busy_fall = busy_d & ~cart_busy;

	assign cart_addr  = {cart_sec, buf_addr};
	assign cart_wdata = buf_rdata;
	assign buf_wdata  = cart_rdata;
	// read data is only valid in the cycle busy falls
	assign buf_we = copy_start & ~copy_done & waiting & busy_fall
		& (copy_dir == bk_ctrl_pkg::DIR_SAVE);

	// cartridge sectors start right after the internal ones
	always_ff @(posedge clk_sys) begin
		cart_sec <= CART_SEC_W'(sd_lba.flat - LBA_W'(bk_geom_pkg::BRAM_SECTORS));
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			busy_d    <= 1'b0;
			waiting   <= 1'b0;
			buf_addr  <= '0;
			copy_done <= 1'b0;
			cart_rd   <= 1'b0;
			cart_wr   <= 1'b0;
		end else begin
			busy_d <= cart_busy;

			// request accepted by the cartridge ram
			if (busy_rise) begin
				cart_rd <= 1'b0;
				cart_wr <= 1'b0;
			end

			if (!copy_start) begin
				buf_addr  <= '0;
				waiting   <= 1'b0;
				copy_done <= 1'b0;
			end else if (!copy_done) begin
				if (!waiting) begin
					cart_wr <= (copy_dir == bk_ctrl_pkg::DIR_LOAD);
					cart_rd <= (copy_dir == bk_ctrl_pkg::DIR_SAVE);
					waiting <= 1'b1;
				end else if (busy_fall) begin
					waiting <= 1'b0;
					if (&buf_addr) begin
						copy_done <= 1'b1;
					end else begin
						buf_addr <= buf_addr + 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- bk_save_top.sv
`timescale 1ns/10ps

module bk_save_top #(
	parameter int CART_SECTORS = 1024
) (
	input  logic clk_sys,
	input  logic rst,
	// downloads, image and menu
	input  logic save_download,
	input  logic rom_download,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic bk_load,
	input  logic bk_save,
	input  logic autosave,
	input  logic osd_status,
	input  logic cart_en,
	input  logic cart_change,
	output logic bk_ena,
	output logic sav_pending,
	output logic bk_busy,
	output logic bk_loading,
	output logic bk_reload,
	// console byte port
	input  logic [bk_geom_pkg::BRAM_ADDR_W-1:0] bram_addr,
	input  logic [7:0] bram_wdata,
	input  logic bram_we,
	output logic [7:0] bram_rdata,
	// sd host
	output logic sd_rd,
	output logic sd_wr,
	output bk_geom_pkg::bk_lba_u sd_lba,
	input  logic sd_ack,
	input  logic [bk_geom_pkg::SD_ADDR_W-1:0] sd_buff_addr,
	input  logic [15:0] sd_buff_dout,
	input  logic sd_buff_wr,
	output logic [15:0] sd_buff_din,
	// cartridge ram
	output logic [bk_geom_pkg::CART_ADDR_W-1:0] cart_addr,
	output logic [7:0] cart_wdata,
	output logic cart_rd,
	output logic cart_wr,
	input  logic cart_busy,
	input  logic [7:0] cart_rdata
);

	logic start;
	logic start_reload;
	bk_ctrl_pkg::bk_dir_e start_dir;
	logic copy_start;
	logic copy_done;
	logic [bk_geom_pkg::BUF_ADDR_W-1:0] buf_addr;
	logic [7:0] buf_wdata;
	logic [7:0] buf_rdata;
	logic buf_we;

	bk_request_ctl u_request_ctl (
		.clk_sys(clk_sys), .rst(rst),
		.save_download(save_download), .rom_download(rom_download),
		.img_mounted(img_mounted), .img_readonly(img_readonly),
		.bk_load(bk_load), .bk_save(bk_save),
		.autosave(autosave), .osd_status(osd_status),
		.bram_we(bram_we), .cart_en(cart_en), .cart_change(cart_change),
		.bk_busy(bk_busy), .bk_ena(bk_ena), .sav_pending(sav_pending),
		.start(start), .start_reload(start_reload), .start_dir(start_dir)
	);

	bk_sector_seq #(.CART_SECTORS(CART_SECTORS)) u_sector_seq (
		.clk_sys(clk_sys), .rst(rst),
		.start(start), .start_reload(start_reload), .start_dir(start_dir),
		.cart_en(cart_en), .sd_ack(sd_ack), .copy_done(copy_done),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba),
		.bk_busy(bk_busy), .bk_loading(bk_loading), .bk_reload(bk_reload),
		.copy_start(copy_start)
	);

	bk_sector_store u_sector_store (
		.clk_sys(clk_sys),
		.bram_addr(bram_addr), .bram_wdata(bram_wdata), .bram_we(bram_we),
		.sd_lba(sd_lba), .sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr), .sd_ack(sd_ack),
		.buf_addr(buf_addr), .buf_wdata(buf_wdata), .buf_we(buf_we),
		.bram_rdata(bram_rdata), .buf_rdata(buf_rdata), .sd_buff_din(sd_buff_din)
	);

	// copy direction follows the transfer direction
	bk_cart_copier u_cart_copier (
		.clk_sys(clk_sys), .rst(rst),
		.copy_start(copy_start), .copy_dir(bk_ctrl_pkg::bk_dir_e'(bk_loading)),
		.sd_lba(sd_lba), .cart_busy(cart_busy), .cart_rdata(cart_rdata),
		.buf_rdata(buf_rdata), .copy_done(copy_done),
		.cart_addr(cart_addr), .cart_wdata(cart_wdata),
		.cart_rd(cart_rd), .cart_wr(cart_wr),
		.buf_addr(buf_addr), .buf_we(buf_we), .buf_wdata(buf_wdata)
	);

endmodule

//--- bk_save_assert.sv
`timescale 1ns/10ps

module bk_save_assert (
	input logic clk_sys,
	input logic rst,
	input logic sd_rd,
	input logic sd_wr,
	input logic cart_rd,
	input logic cart_wr,
	input logic bk_busy,
	input logic bk_loading,
	input logic bk_reload,
	input bk_ctrl_pkg::seq_state_e phase
);

	// one sd direction at a time
	sd_one_dir: assert property (@(posedge clk_sys) disable iff (rst) !(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

	cart_one_dir: assert property (@(posedge clk_sys) disable iff (rst) !(cart_rd && cart_wr))
		else $error("cart_rd and cart_wr high together");

	// requests only inside a transfer
	sd_req_busy: assert property (@(posedge clk_sys) disable iff (rst)
		(sd_rd || sd_wr) |-> bk_busy)
		else $error("sd request outside a transfer");

	reload_is_load: assert property (@(posedge clk_sys) disable iff (rst)
		bk_reload |-> bk_loading)
		else $error("bk_reload without bk_loading");

	// cartridge bytes move only once a sector phase is under way
	cart_in_phase: assert property (@(posedge clk_sys) disable iff (rst)
		(cart_rd || cart_wr) |-> (phase != bk_ctrl_pkg::SEQ_ISSUE))
		else $error("cartridge access while the sector phase is still at issue");

endmodule

bind bk_save_top bk_save_assert u_bk_save_assert (
	.clk_sys(clk_sys),
	.rst(rst),
	.sd_rd(sd_rd),
	.sd_wr(sd_wr),
	.cart_rd(cart_rd),
	.cart_wr(cart_wr),
	.bk_busy(bk_busy),
	.bk_loading(bk_loading),
	.bk_reload(bk_reload),
	.phase(u_sector_seq.phase)
);

//--- tb_bk_save.sv
`timescale 1ns/10ps

module tb_bk_save;

	localparam int CART_SECTORS = 4;
	localparam int BRAM_BYTES = bk_geom_pkg::BRAM_SECTORS * bk_geom_pkg::SECTOR_WORDS * 2;
	localparam int CART_BYTES = CART_SECTORS * bk_geom_pkg::SECTOR_WORDS * 2;
	// six transfers of up to 20 sectors, generous per sector
	localparam int TIMEOUT_CYCLES = 6 * 20 * 2000;

	logic clk_sys;
	logic rst;
	logic save_download;
	logic rom_download;
	logic img_mounted;
	logic img_readonly;
	logic bk_load;
	logic bk_save;
	logic autosave;
	logic osd_status;
	logic cart_en;
	logic cart_change;
	logic bk_ena;
	logic sav_pending;
	logic bk_busy;
	logic bk_loading;
	logic bk_reload;
	logic [bk_geom_pkg::BRAM_ADDR_W-1:0] bram_addr;
	logic [7:0] bram_wdata;
	logic bram_we;
	logic [7:0] bram_rdata;
	logic sd_rd;
	logic sd_wr;
	bk_geom_pkg::bk_lba_u sd_lba;
	logic sd_ack;
	logic [bk_geom_pkg::SD_ADDR_W-1:0] sd_buff_addr;
	logic [15:0] sd_buff_dout;
	logic sd_buff_wr;
	logic [15:0] sd_buff_din;
	logic [bk_geom_pkg::CART_ADDR_W-1:0] cart_addr;
	logic [7:0] cart_wdata;
	logic cart_rd;
	logic cart_wr;
	logic cart_busy;
	logic [7:0] cart_rdata;

	// expected contents of both image regions
	logic [7:0] bram_shadow [BRAM_BYTES];
	logic [7:0] cart_shadow [CART_BYTES];
	// cartridge ram as the model holds it
	logic [7:0] cart_mem [CART_BYTES];

	logic [31:0] rng_state = 32'hcdda8e88;
	string test_name = "reset";
	int cycle_count = 0;
	int err_count = 0;
	int sectors_done = 0;
	logic exp_load = 1'b0;
	logic req_seen = 1'b0;

	bk_save_top #(.CART_SECTORS(CART_SECTORS)) u_bk_save_top (
		.clk_sys(clk_sys), .rst(rst),
		.save_download(save_download), .rom_download(rom_download),
		.img_mounted(img_mounted), .img_readonly(img_readonly),
		.bk_load(bk_load), .bk_save(bk_save),
		.autosave(autosave), .osd_status(osd_status),
		.cart_en(cart_en), .cart_change(cart_change),
		.bk_ena(bk_ena), .sav_pending(sav_pending), .bk_busy(bk_busy),
		.bk_loading(bk_loading), .bk_reload(bk_reload),
		.bram_addr(bram_addr), .bram_wdata(bram_wdata), .bram_we(bram_we),
		.bram_rdata(bram_rdata),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba), .sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr), .sd_buff_din(sd_buff_din),
		.cart_addr(cart_addr), .cart_wdata(cart_wdata),
		.cart_rd(cart_rd), .cart_wr(cart_wr),
		.cart_busy(cart_busy), .cart_rdata(cart_rdata)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// random data and reference

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = lcg_next();
		return r[23:16];
	endfunction

	// byte 2w in the low half, byte 2w+1 in the high half
	function automatic logic [15:0] expected_word(int sector, int w);
		int base;
		if (sector < bk_geom_pkg::BRAM_SECTORS) begin
			base = sector * 512 + 2 * w;
			return {bram_shadow[base + 1], bram_shadow[base]};
		end
		base = (sector - bk_geom_pkg::BRAM_SECTORS) * 512 + 2 * w;
		return {cart_shadow[base + 1], cart_shadow[base]};
	endfunction

	task automatic store_word(int sector, int w, logic [7:0] lo, logic [7:0] hi);
		int base;
		if (sector < bk_geom_pkg::BRAM_SECTORS) begin
			base = sector * 512 + 2 * w;
			bram_shadow[base] = lo;
			bram_shadow[base + 1] = hi;
		end else begin
			base = (sector - bk_geom_pkg::BRAM_SECTORS) * 512 + 2 * w;
			cart_shadow[base] = lo;
			cart_shadow[base + 1] = hi;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare tasks

	task automatic stop_failed();
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(string what, logic [15:0] exp, logic [15:0] act);
		if (exp !== act) begin
			err_count++;
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_byte(string what, logic [7:0] exp, logic [7:0] act);
		if (exp !== act) begin
			err_count++;
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_flag(string what, logic exp, logic act);
		if (exp !== act) begin
			err_count++;
			$display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_lba(string what, bk_geom_pkg::bk_lba_u exp, bk_geom_pkg::bk_lba_u act);
		if (exp.flat !== act.flat) begin
			err_count++;
			$display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what,
				exp.flat, act.flat);
			stop_failed();
		end
	endtask

	initial begin : watchdog
		forever begin
			@(posedge clk_sys);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES) begin
				$display("%s: no end of the run after %0d cycles", test_name, cycle_count);
				stop_failed();
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// sd host, streams one sector per request

	initial begin : sd_host
		int w;
		logic [7:0] lo;
		logic [7:0] hi;
		logic loading;
		bk_geom_pkg::bk_lba_u lba;
		bk_geom_pkg::bk_lba_u exp_lba;
		forever begin
			@(posedge clk_sys);
			if (!rst && (sd_rd || sd_wr)) begin
				req_seen = 1'b1;
				lba = sd_lba;
				loading = sd_rd;
				exp_lba.flat = 11'(sectors_done);
				check_lba("sector number", exp_lba, lba);
				check_flag("sd_rd", exp_load, sd_rd);
				check_flag("sd_wr", ~exp_load, sd_wr);
				repeat (3) @(posedge clk_sys);
				sd_ack <= 1'b1;
				for (w = 0; w < bk_geom_pkg::SECTOR_WORDS; w++) begin
					@(posedge clk_sys);
					sd_buff_addr <= 8'(w);
					if (loading) begin
						lo = rand_byte();
						hi = rand_byte();
						store_word(int'(lba.flat), w, lo, hi);
						sd_buff_dout <= {hi, lo};
						sd_buff_wr <= 1'b1;
					end
					@(posedge clk_sys);
					sd_buff_wr <= 1'b0;
					// registered read, word is out two edges after its address
					@(posedge clk_sys);
					if (!loading) begin
						check_word($sformatf("sector %0d word %0d", lba.flat, w),
							expected_word(int'(lba.flat), w), sd_buff_din);
					end
				end
				@(posedge clk_sys);
				sd_ack <= 1'b0;
				sectors_done++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// cartridge ram, two-cycle busy pulse per byte

	initial begin : cart_ram
		int a;
		forever begin
			@(posedge clk_sys);
			if (!rst && (cart_rd || cart_wr)) begin
				if (cart_addr >= 19'(CART_BYTES)) begin
					$display("%s: cartridge address %h is outside the ram", test_name, cart_addr);
					stop_failed();
				end
				a = int'(cart_addr);
				if (cart_wr) begin
					cart_mem[a] = cart_wdata;
				end
				cart_rdata <= cart_mem[a];
				cart_busy <= 1'b1;
				@(posedge clk_sys);
				@(posedge clk_sys);
				cart_busy <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers

	task automatic console_write_all();
		int a;
		logic [7:0] b;
		for (a = 0; a < BRAM_BYTES; a++) begin
			b = rand_byte();
			@(posedge clk_sys);
			bram_addr <= 13'(a);
			bram_wdata <= b;
			bram_we <= 1'b1;
			bram_shadow[a] = b;
		end
		@(posedge clk_sys);
		bram_we <= 1'b0;
	endtask

	task automatic console_check_all();
		int a;
		for (a = 0; a < BRAM_BYTES; a++) begin
			@(posedge clk_sys);
			bram_addr <= 13'(a);
			repeat (2) @(posedge clk_sys);
			check_byte($sformatf("bram_rdata at %0d", a), bram_shadow[a], bram_rdata);
		end
	endtask

	task automatic prepare_transfer(logic load);
		exp_load = load;
		sectors_done = 0;
	endtask

	// wait for the whole transfer, checking its flags on the way
	task automatic run_transfer(logic load, logic reload, int n_sectors);
		@(posedge clk_sys);
		while (!bk_busy) begin
			@(posedge clk_sys);
		end
		check_flag("bk_loading", load, bk_loading);
		check_flag("bk_reload", reload, bk_reload);
		while (bk_busy) begin
			@(posedge clk_sys);
		end
		check_word("sector count", 16'(n_sectors), 16'(sectors_done));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin : main
		int i;
		logic [7:0] b;
		rst = 1'b1;
		save_download = 1'b0;
		rom_download = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		autosave = 1'b0;
		osd_status = 1'b0;
		cart_en = 1'b0;
		cart_change = 1'b0;
		bram_addr = '0;
		bram_wdata = '0;
		bram_we = 1'b0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		cart_busy = 1'b0;
		cart_rdata = '0;
		repeat (4) @(posedge clk_sys);
		rst <= 1'b0;

		test_name = "arming";
		@(posedge clk_sys);
		bk_save <= 1'b1;
		@(posedge clk_sys);
		bk_save <= 1'b0;
		repeat (20) @(posedge clk_sys);
		check_flag("request before arming", 1'b0, req_seen);
		check_flag("bk_busy", 1'b0, bk_busy);
		save_download <= 1'b1;
		img_mounted <= 1'b1;
		img_readonly <= 1'b1;
		repeat (4) @(posedge clk_sys);
		check_flag("bk_ena readonly", 1'b0, bk_ena);
		save_download <= 1'b0;
		img_mounted <= 1'b0;
		repeat (2) @(posedge clk_sys);
		save_download <= 1'b1;
		img_mounted <= 1'b1;
		img_readonly <= 1'b0;
		repeat (4) @(posedge clk_sys);
		check_flag("bk_ena writable", 1'b1, bk_ena);
		save_download <= 1'b0;
		img_mounted <= 1'b0;

		test_name = "internal save";
		console_write_all();
		prepare_transfer(1'b0);
		@(posedge clk_sys);
		bk_save <= 1'b1;
		@(posedge clk_sys);
		bk_save <= 1'b0;
		run_transfer(1'b0, 1'b0, 16);

		test_name = "internal load";
		prepare_transfer(1'b1);
		@(posedge clk_sys);
		bk_load <= 1'b1;
		@(posedge clk_sys);
		bk_load <= 1'b0;
		run_transfer(1'b1, 1'b1, 16);
		console_check_all();

		test_name = "cartridge save";
		for (i = 0; i < CART_BYTES; i++) begin
			b = rand_byte();
			cart_mem[i] = b;
			cart_shadow[i] = b;
		end
		cart_en <= 1'b1;
		prepare_transfer(1'b0);
		@(posedge clk_sys);
		bk_save <= 1'b1;
		@(posedge clk_sys);
		bk_save <= 1'b0;
		run_transfer(1'b0, 1'b0, 16 + CART_SECTORS);

		test_name = "cartridge load";
		prepare_transfer(1'b1);
		@(posedge clk_sys);
		bk_load <= 1'b1;
		@(posedge clk_sys);
		bk_load <= 1'b0;
		run_transfer(1'b1, 1'b1, 16 + CART_SECTORS);
		for (i = 0; i < CART_BYTES; i++) begin
			check_byte($sformatf("cart_mem at %0d", i), cart_shadow[i], cart_mem[i]);
		end
		cart_en <= 1'b0;

		test_name = "autosave";
		b = rand_byte();
		@(posedge clk_sys);
		bram_addr <= 13'd100;
		bram_wdata <= b;
		bram_we <= 1'b1;
		bram_shadow[100] = b;
		@(posedge clk_sys);
		bram_we <= 1'b0;
		repeat (3) @(posedge clk_sys);
		check_flag("sav_pending after write", 1'b1, sav_pending);
		prepare_transfer(1'b0);
		autosave <= 1'b1;
		osd_status <= 1'b1;
		run_transfer(1'b0, 1'b0, 16);
		check_flag("sav_pending after save", 1'b0, sav_pending);
		osd_status <= 1'b0;
		repeat (4) @(posedge clk_sys);
		req_seen = 1'b0;
		osd_status <= 1'b1;
		repeat (40) @(posedge clk_sys);
		check_flag("request with nothing pending", 1'b0, req_seen);
		check_flag("bk_busy", 1'b0, bk_busy);
		osd_status <= 1'b0;

		test_name = "rom download end";
		prepare_transfer(1'b1);
		@(posedge clk_sys);
		rom_download <= 1'b1;
		repeat (5) @(posedge clk_sys);
		rom_download <= 1'b0;
		run_transfer(1'b1, 1'b0, 16);
		console_check_all();

		if (err_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			stop_failed();
		end
	end

endmodule

//--- flist.f
bk_geom_pkg.sv
bk_ctrl_pkg.sv
bk_request_ctl.sv
bk_sector_seq.sv
bk_sector_store.sv
bk_cart_copier.sv
bk_save_top.sv
bk_save_assert.sv
tb_bk_save.sv

//--- run.sh
#!/bin/sh
# compile and run the backup-ram testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_bk_save \
	-f flist.f \
	-o sim_bk_save

# a failing run ends in $fatal and a non-zero exit status
./obj_dir/sim_bk_save
